// File: source/packet_pkg.sv
// Geometry is fixed here: two contexts, each owning one 32-word region of a 64-word memory.
// Region depth must stay a power of two so offsets wrap on their own.
`default_nettype none

package packet_pkg;

    // ----------------------------------------
    // Geometry
    // ----------------------------------------
    localparam int NUM_CONTEXTS  = 2;
    localparam int CTXT_WID      = 1;
    localparam int DATA_WID      = 32;
    localparam int REGION_DEPTH  = 32;
    localparam int OFFSET_WID    = 5;
    localparam int ADDR_WID      = 6;
    localparam int MEM_DEPTH     = NUM_CONTEXTS * REGION_DEPTH;
    localparam int MAX_PKT_WORDS = 16;

    // Sizes run 1..16, free counts 0..32
    localparam int SIZE_WID      = 5;
    localparam int COUNT_WID     = 6;

    // Descriptor queue, per context
    localparam int DESC_DEPTH    = 4;
    localparam int DESC_PTR_WID  = 2;
    localparam int DESC_CNT_WID  = 3;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic [CTXT_WID-1:0]   ctxt_t;
    typedef logic [DATA_WID-1:0]   data_t;
    typedef logic [ADDR_WID-1:0]   addr_t;
    typedef logic [OFFSET_WID-1:0] offset_t;
    typedef logic [SIZE_WID-1:0]   size_t;
    typedef logic [COUNT_WID-1:0]  count_t;

    // Dequeue FSM
    typedef enum logic [1:0] {
        idle,
        reading,
        draining
    } deq_state_t;

endpackage : packet_pkg

`default_nettype wire

// File: source/packet_mem.sv
// Single port, one-cycle registered read. No reset; contents are undefined until written.
`timescale 1ns/1ns
`default_nettype none

module packet_mem
    import packet_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  mem_en,
    input  wire logic  mem_we,
    input  wire addr_t mem_addr,
    input  wire data_t mem_wdata,
    output data_t      mem_rdata
);

    // Both regions share one array, context bit on top
    data_t mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end else begin
                // Read word only updates on a read access
                mem_rdata <= mem[mem_addr];
            end
        end
    end

endmodule : packet_mem

`default_nettype wire

// File: source/mem_arbiter.sv
// Writes always win the port. A read granted in one cycle returns its word the next cycle.
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter
    import packet_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,

    // Write side from enqueue
    input  wire logic  wr_req,
    input  wire addr_t wr_addr,
    input  wire data_t wr_data,
    output logic       wr_gnt,

    // Read side from dequeue
    input  wire logic  rd_req,
    input  wire addr_t rd_addr,
    output logic       rd_gnt,
    output logic       rd_data_valid,
    output data_t      rd_data,

    // Memory port
    output logic       mem_en,
    output logic       mem_we,
    output addr_t      mem_addr,
    output data_t      mem_wdata,
    input  wire data_t mem_rdata
);

    logic rd_pending;

    // ----------------------------------------
    // Fixed priority grant
    // ----------------------------------------
    assign wr_gnt = wr_req;
    assign rd_gnt = rd_req && !wr_req;

    assign mem_en    = wr_req || rd_req;
    assign mem_we    = wr_req;
    assign mem_addr  = wr_req ? wr_addr : rd_addr;
    assign mem_wdata = wr_data;

    // Marks the word coming back from last cycle's read
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= rd_gnt;
        end
    end

    assign rd_data_valid = rd_pending;
    assign rd_data       = mem_rdata;

    // No copy of a losing read is kept here so the requester must hold it
    a_rd_held: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_gnt |=> rd_req && $stable(rd_addr))
        else $error("mem_arbiter: read request dropped while waiting for the port");

endmodule : mem_arbiter

`default_nettype wire

// File: source/packet_enqueue.sv
// All words of a packet must carry the same context and a packet is at most 16 words.
// Space is reclaimed only when dequeue returns the read descriptor.
`timescale 1ns/1ns
`default_nettype none

module packet_enqueue
    import packet_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,

    // Input stream
    input  wire logic  in_valid,
    input  wire data_t in_data,
    input  wire logic  in_eop,
    input  wire ctxt_t in_ctxt,
    output logic       in_rdy,

    // Memory write port
    output logic       wr_req,
    output addr_t      wr_addr,
    output data_t      wr_data,
    input  wire logic  wr_gnt,

    // Write descriptors, one queue per context
    output logic [NUM_CONTEXTS-1:0] desc_valid,
    output addr_t      desc_addr [NUM_CONTEXTS],
    output size_t      desc_size [NUM_CONTEXTS],
    input  wire logic  desc_ack,
    input  wire ctxt_t desc_ack_ctxt,

    // Read descriptor return
    input  wire logic  rd_desc_valid,
    input  wire ctxt_t rd_desc_ctxt,
    input  wire size_t rd_desc_size
);

    logic ready_q;

    // Per-context region state
    offset_t wr_offset [NUM_CONTEXTS];
    offset_t pkt_start [NUM_CONTEXTS];
    size_t   pkt_size  [NUM_CONTEXTS];
    count_t  free_cnt  [NUM_CONTEXTS];
    count_t  free_next [NUM_CONTEXTS];

    // Descriptor queues
    addr_t                    q_addr [NUM_CONTEXTS][DESC_DEPTH];
    size_t                    q_size [NUM_CONTEXTS][DESC_DEPTH];
    logic [DESC_PTR_WID-1:0]  q_head [NUM_CONTEXTS];
    logic [DESC_PTR_WID-1:0]  q_tail [NUM_CONTEXTS];
    logic [DESC_CNT_WID-1:0]  q_cnt  [NUM_CONTEXTS];

    logic [NUM_CONTEXTS-1:0] word_fire;
    logic [NUM_CONTEXTS-1:0] desc_push;
    logic [NUM_CONTEXTS-1:0] desc_pop;
    logic [NUM_CONTEXTS-1:0] ret_hit;

    // ----------------------------------------
    // Input acceptance and memory write
    // ----------------------------------------
    assign in_rdy  = ready_q && (free_cnt[in_ctxt] != '0) &&
                     (q_cnt[in_ctxt] != DESC_CNT_WID'(DESC_DEPTH));
    assign wr_req  = in_valid && in_rdy;
    assign wr_addr = {in_ctxt, wr_offset[in_ctxt]};
    assign wr_data = in_data;

    for (genvar g = 0; g < NUM_CONTEXTS; g++) begin : g_ctxt
        assign word_fire[g] = wr_req && wr_gnt && (in_ctxt == ctxt_t'(g));
        assign desc_push[g] = word_fire[g] && in_eop;
        assign desc_pop[g]  = desc_ack && (desc_ack_ctxt == ctxt_t'(g));
        assign ret_hit[g]   = rd_desc_valid && (rd_desc_ctxt == ctxt_t'(g));

        // One word taken, a finished packet given back
        assign free_next[g] = free_cnt[g] - count_t'(word_fire[g]) +
                              (ret_hit[g] ? count_t'(rd_desc_size) : count_t'(0));

        assign desc_valid[g] = (q_cnt[g] != '0);
        assign desc_addr[g]  = q_addr[g][q_head[g]];
        assign desc_size[g]  = q_size[g][q_head[g]];

        a_free_bound: assert property (@(posedge clk) disable iff (reset)
            free_cnt[g] <= count_t'(REGION_DEPTH))
            else $error("packet_enqueue: free count overflow on context %0d", g);

        a_pkt_len: assert property (@(posedge clk) disable iff (reset)
            word_fire[g] |-> (pkt_size[g] < size_t'(MAX_PKT_WORDS)))
            else $error("packet_enqueue: packet longer than %0d words", MAX_PKT_WORDS);
    end : g_ctxt

    // ----------------------------------------
    // Region and queue control
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q <= 1'b0;
            for (int c = 0; c < NUM_CONTEXTS; c++) begin
                wr_offset[c] <= '0;
                pkt_start[c] <= '0;
                pkt_size[c]  <= '0;
                free_cnt[c]  <= count_t'(REGION_DEPTH);
                q_head[c]    <= '0;
                q_tail[c]    <= '0;
                q_cnt[c]     <= '0;
            end
        end else begin
            ready_q <= 1'b1;
            for (int c = 0; c < NUM_CONTEXTS; c++) begin
                free_cnt[c] <= free_next[c];
                if (word_fire[c]) begin
                    wr_offset[c] <= wr_offset[c] + 1'b1;
                    if (in_eop) begin
                        // Next packet starts right after this one
                        pkt_start[c] <= wr_offset[c] + 1'b1;
                        pkt_size[c]  <= '0;
                        q_tail[c]    <= q_tail[c] + 1'b1;
                    end else begin
                        pkt_size[c] <= pkt_size[c] + 1'b1;
                    end
                end
                if (desc_pop[c]) begin
                    q_head[c] <= q_head[c] + 1'b1;
                end
                case ({desc_push[c], desc_pop[c]})
                    2'b10:   q_cnt[c] <= q_cnt[c] + 1'b1;
                    2'b01:   q_cnt[c] <= q_cnt[c] - 1'b1;
                    default: q_cnt[c] <= q_cnt[c];
                endcase
            end
        end
    end

    // Descriptor entries
    always_ff @(posedge clk) begin
        for (int c = 0; c < NUM_CONTEXTS; c++) begin
            if (desc_push[c]) begin
                q_addr[c][q_tail[c]] <= {ctxt_t'(c), pkt_start[c]};
                q_size[c][q_tail[c]] <= pkt_size[c] + 1'b1;
            end
        end
    end

endmodule : packet_enqueue

`default_nettype wire

// File: source/packet_dequeue.sv
// Serves one packet at a time, contexts in round-robin order. Space is returned only after
// the eop word has left, so a stalled output holds the packet in memory.
`timescale 1ns/1ns
`default_nettype none

module packet_dequeue
    import packet_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,

    // Write descriptors from enqueue
    input  wire logic [NUM_CONTEXTS-1:0] desc_valid,
    input  wire addr_t desc_addr [NUM_CONTEXTS],
    input  wire size_t desc_size [NUM_CONTEXTS],
    output logic       desc_ack,
    output ctxt_t      desc_ack_ctxt,

    // Memory read port
    output logic       rd_req,
    output addr_t      rd_addr,
    input  wire logic  rd_gnt,
    input  wire logic  rd_data_valid,
    input  wire data_t rd_data,

    // Output stream
    output logic       out_valid,
    output data_t      out_data,
    output logic       out_eop,
    output ctxt_t      out_ctxt,
    input  wire logic  out_rdy,

    // Read descriptor return
    output logic       rd_desc_valid,
    output ctxt_t      rd_desc_ctxt,
    output size_t      rd_desc_size
);

    deq_state_t state;

    // Context being served, also the round-robin pointer
    ctxt_t last_ctxt;
    logic  pick_valid;
    ctxt_t pick_ctxt;

    size_t cur_size;
    size_t issue_cnt;
    size_t recv_cnt;
    addr_t rd_addr_q;
    logic  last_word;

    // 2-entry output buffer
    data_t      buf_data [2];
    logic       buf_eop  [2];
    logic       buf_wr_ptr;
    logic       buf_rd_ptr;
    logic [1:0] buf_cnt;
    logic [1:0] buf_cnt_next;
    logic       push;
    logic       pop;

    // ----------------------------------------
    // Round-robin pick
    // ----------------------------------------
    always_comb begin
        ctxt_t cand;
        pick_valid = 1'b0;
        pick_ctxt  = last_ctxt;
        // Walk from farthest to nearest so the nearest pending context wins
        for (int i = NUM_CONTEXTS; i >= 1; i--) begin
            cand = ctxt_t'((int'(last_ctxt) + i) % NUM_CONTEXTS);
            if (desc_valid[cand]) begin
                pick_valid = 1'b1;
                pick_ctxt  = cand;
            end
        end
    end

    assign desc_ack      = (state == idle) && pick_valid;
    assign desc_ack_ctxt = pick_ctxt;

    // ----------------------------------------
    // Read issue and output buffer
    // ----------------------------------------
    assign push         = rd_data_valid;
    assign pop          = out_valid && out_rdy;
    assign buf_cnt_next = buf_cnt + {1'b0, push} - {1'b0, pop};
    assign last_word    = (recv_cnt + 1'b1) == cur_size;

    // Only issue if the word can land next cycle
    assign rd_req  = (state == reading) && (issue_cnt != cur_size) && (buf_cnt_next < 2'd2);
    assign rd_addr = rd_addr_q;

    assign out_valid = (buf_cnt != 2'd0);
    assign out_data  = buf_data[buf_rd_ptr];
    assign out_eop   = buf_eop[buf_rd_ptr];
    assign out_ctxt  = last_ctxt;

    assign rd_desc_ctxt = last_ctxt;
    assign rd_desc_size = cur_size;

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= idle;
            last_ctxt     <= ctxt_t'(NUM_CONTEXTS - 1);
            issue_cnt     <= '0;
            recv_cnt      <= '0;
            buf_cnt       <= '0;
            buf_wr_ptr    <= 1'b0;
            buf_rd_ptr    <= 1'b0;
            rd_desc_valid <= 1'b0;
        end else begin
            rd_desc_valid <= 1'b0;
            buf_cnt       <= buf_cnt_next;
            if (push) begin
                buf_wr_ptr <= ~buf_wr_ptr;
            end
            if (pop) begin
                buf_rd_ptr <= ~buf_rd_ptr;
            end
            case (state)
                idle: begin
                    if (pick_valid) begin
                        state     <= reading;
                        last_ctxt <= pick_ctxt;
                        issue_cnt <= '0;
                        recv_cnt  <= '0;
                    end
                end
                reading: begin
                    if (rd_req && rd_gnt) begin
                        issue_cnt <= issue_cnt + 1'b1;
                    end
                    if (push) begin
                        recv_cnt <= recv_cnt + 1'b1;
                        if (last_word) begin
                            state <= draining;
                        end
                    end
                end
                draining: begin
                    // Free the space once eop is taken
                    if (pop && out_eop) begin
                        rd_desc_valid <= 1'b1;
                        state         <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Descriptor latch, read address walk and buffer payload
    always_ff @(posedge clk) begin
        if (desc_ack) begin
            cur_size  <= desc_size[pick_ctxt];
            rd_addr_q <= desc_addr[pick_ctxt];
        end else if (rd_req && rd_gnt) begin
            rd_addr_q <= {rd_addr_q[ADDR_WID-1:OFFSET_WID], rd_addr_q[OFFSET_WID-1:0] + 1'b1};
        end
        if (push) begin
            buf_data[buf_wr_ptr] <= rd_data;
            buf_eop[buf_wr_ptr]  <= last_word;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_rdy |=> out_valid && $stable(out_data) && $stable(out_eop))
        else $error("packet_dequeue: output changed while stalled");

endmodule : packet_dequeue

`default_nettype wire

// File: source/packet_buffer_top.sv
// Two-context packet buffer over one shared memory. Latency from eop in to first word out
// varies with memory contention and with the other context's traffic.
`timescale 1ns/1ns
`default_nettype none

module packet_buffer_top
    import packet_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  reset,

    // Input stream
    input  wire logic  in_valid,
    input  wire data_t in_data,
    input  wire logic  in_eop,
    input  wire ctxt_t in_ctxt,
    output logic       in_rdy,

    // Output stream
    output logic       out_valid,
    output data_t      out_data,
    output logic       out_eop,
    output ctxt_t      out_ctxt,
    input  wire logic  out_rdy
);

    // ----------------------------------------
    // Internal wiring
    // ----------------------------------------
    logic [NUM_CONTEXTS-1:0] desc_valid;
    addr_t desc_addr [NUM_CONTEXTS];
    size_t desc_size [NUM_CONTEXTS];
    logic  desc_ack;
    ctxt_t desc_ack_ctxt;

    logic  rd_desc_valid;
    ctxt_t rd_desc_ctxt;
    size_t rd_desc_size;

    logic  wr_req;
    addr_t wr_addr;
    data_t wr_data;
    logic  wr_gnt;
    logic  rd_req;
    addr_t rd_addr;
    logic  rd_gnt;
    logic  rd_data_valid;
    data_t rd_data;

    logic  mem_en;
    logic  mem_we;
    addr_t mem_addr;
    data_t mem_wdata;
    data_t mem_rdata;

    packet_enqueue u_enqueue (
        .clk, .reset,
        .in_valid, .in_data, .in_eop, .in_ctxt, .in_rdy,
        .wr_req, .wr_addr, .wr_data, .wr_gnt,
        .desc_valid, .desc_addr, .desc_size, .desc_ack, .desc_ack_ctxt,
        .rd_desc_valid, .rd_desc_ctxt, .rd_desc_size
    );

    packet_dequeue u_dequeue (
        .clk, .reset,
        .desc_valid, .desc_addr, .desc_size, .desc_ack, .desc_ack_ctxt,
        .rd_req, .rd_addr, .rd_gnt, .rd_data_valid, .rd_data,
        .out_valid, .out_data, .out_eop, .out_ctxt, .out_rdy,
        .rd_desc_valid, .rd_desc_ctxt, .rd_desc_size
    );

    mem_arbiter u_arbiter (
        .clk, .reset,
        .wr_req, .wr_addr, .wr_data, .wr_gnt,
        .rd_req, .rd_addr, .rd_gnt, .rd_data_valid, .rd_data,
        .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
    );

    packet_mem u_mem (
        .clk,
        .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
    );

endmodule : packet_buffer_top

`default_nettype wire

// File: verification/packet_buffer_tb.sv
// Drives packet_buffer_top through six tests against a per-context model of expected words.
// Stimulus changes on the falling edge and outputs are checked on the rising edge.
`timescale 1ns/1ns
`default_nettype none

module packet_buffer_tb
    import packet_pkg::*;
();

    localparam int CLK_PERIOD  = 20;
    localparam int TOTAL_PKTS  = 45;
    localparam int WATCHDOG_NS = TOTAL_PKTS * 200 * CLK_PERIOD;
    localparam int DRAIN_LIMIT = 4000;
    localparam int RDY_HIGH    = 0;
    localparam int RDY_LOW     = 1;
    localparam int RDY_RANDOM  = 2;

    logic  clk;
    logic  reset;
    logic  in_valid;
    data_t in_data;
    logic  in_eop;
    ctxt_t in_ctxt;
    logic  in_rdy;
    logic  out_valid;
    data_t out_data;
    logic  out_eop;
    ctxt_t out_ctxt;
    logic  out_rdy;

    // Model state, entries are {eop, data}
    logic [DATA_WID:0] exp_q0 [$];
    logic [DATA_WID:0] exp_q1 [$];
    ctxt_t             pkt_order [$];
    int                occ [NUM_CONTEXTS];
    int                err_cnt;
    int                bad_tests;
    int                words_out;
    int                rdy_mode;
    logic [31:0]       stim_seed;
    logic [31:0]       rdy_seed;

    packet_buffer_top u_dut (
        .clk, .reset,
        .in_valid, .in_data, .in_eop, .in_ctxt, .in_rdy,
        .out_valid, .out_data, .out_eop, .out_ctxt, .out_rdy
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_seed = lcg_next(stim_seed);
        return stim_seed;
    endfunction

    function automatic int pick_len(input int max_len);
        logic [31:0] r;
        r = next_stim();
        return 1 + int'(r[23:8]) % max_len;
    endfunction

    task automatic flag_mismatch(input string msg);
        $display("ERR %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic flag_failure(input string msg);
        $display("%s", msg);
        err_cnt++;
    endtask

    task automatic finish_test(input int num, input string name, input int err_start);
        $display("test %0d %s: %0d errors", num, name, err_cnt - err_start);
        if (err_cnt != err_start) begin
            bad_tests++;
        end
    endtask

    // Mode takes effect on the next falling edge
    task automatic set_rdy(input int mode);
        @(posedge clk);
        rdy_mode = mode;
    endtask

    task automatic send_packet(input ctxt_t ctxt, input int len);
        data_t word;
        logic  eop;
        for (int i = 0; i < len; i++) begin
            word = next_stim();
            eop  = (i == len - 1);
            @(negedge clk);
            in_valid = 1'b1;
            in_data  = word;
            in_eop   = eop;
            in_ctxt  = ctxt;
            @(posedge clk);
            while (!in_rdy) begin
                @(posedge clk);
            end
            if (ctxt == 1'b0) begin
                exp_q0.push_back({eop, word});
            end else begin
                exp_q1.push_back({eop, word});
            end
            occ[ctxt]++;
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_eop   = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            flag_failure($sformatf("output stream did not drain, %0d and %0d words missing",
                                   exp_q0.size(), exp_q1.size()));
        end
        repeat (4) @(negedge clk);
    endtask

    // ----------------------------------------
    // Output side
    // ----------------------------------------
    always @(negedge clk) begin
        case (rdy_mode)
            RDY_LOW: out_rdy = 1'b0;
            RDY_RANDOM: begin
                rdy_seed = lcg_next(rdy_seed);
                out_rdy  = rdy_seed[29];
            end
            default: out_rdy = 1'b1;
        endcase
    end

    always @(posedge clk) begin : monitor
        logic [DATA_WID:0] exp;
        if (!reset && out_valid && out_rdy) begin
            words_out++;
            if ((out_ctxt == 1'b0) ? (exp_q0.size() == 0) : (exp_q1.size() == 0)) begin
                flag_mismatch($sformatf("unexpected word %h on context %0d", out_data, out_ctxt));
            end else begin
                exp = (out_ctxt == 1'b0) ? exp_q0.pop_front() : exp_q1.pop_front();
                occ[out_ctxt]--;
                assert (out_data == exp[DATA_WID-1:0] && out_eop == exp[DATA_WID])
                    else flag_mismatch($sformatf("context %0d got %h eop %b, expected %h eop %b",
                        out_ctxt, out_data, out_eop, exp[DATA_WID-1:0], exp[DATA_WID]));
            end
            if (out_eop) begin
                pkt_order.push_back(out_ctxt);
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk) reset |=> !out_valid && !in_rdy)
        else flag_mismatch("out_valid or in_rdy high during reset");

    a_rdy_rises: assert property (@(posedge clk) $fell(reset) |=> in_rdy)
        else flag_mismatch("in_rdy did not rise after reset");

    a_stall_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_rdy |=> out_valid && $stable(out_data) && $stable(out_eop) &&
                                  $stable(out_ctxt))
        else flag_mismatch("output changed while stalled");

    // Model occupancy never exceeds what the region can hold
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        in_valid && in_rdy |-> occ[in_ctxt] < REGION_DEPTH)
        else flag_mismatch("word accepted into a full region");

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    initial begin : stimulus
        int err_start;
        int stall_cycles;
        int waited;
        clk       = 1'b0;
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_data   = '0;
        in_eop    = 1'b0;
        in_ctxt   = '0;
        out_rdy   = 1'b0;
        rdy_mode  = RDY_HIGH;
        occ[0]    = 0;
        occ[1]    = 0;
        err_cnt   = 0;
        bad_tests = 0;
        words_out = 0;
        stim_seed = 32'hb23a_9dea;
        rdy_seed  = lcg_next(32'hb23a_9dea);
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        err_start = err_cnt;
        repeat (10) @(posedge clk);
        assert (words_out == 0 && in_rdy) else flag_mismatch("output not idle after reset");
        finish_test(1, "reset idle", err_start);

        err_start = err_cnt;
        for (int p = 0; p < 6; p++) begin
            send_packet(1'b1, pick_len(MAX_PKT_WORDS));
        end
        wait_drain();
        finish_test(2, "single context", err_start);

        err_start = err_cnt;
        for (int p = 0; p < 20; p++) begin
            send_packet(ctxt_t'(next_stim() >> 31), pick_len(MAX_PKT_WORDS));
        end
        wait_drain();
        finish_test(3, "mixed contexts", err_start);

        err_start = err_cnt;
        set_rdy(RDY_LOW);
        pkt_order.delete();
        for (int p = 0; p < 3; p++) begin
            send_packet(1'b0, pick_len(10));
        end
        for (int p = 0; p < 3; p++) begin
            send_packet(1'b1, pick_len(10));
        end
        set_rdy(RDY_HIGH);
        wait_drain();
        assert (pkt_order.size() == 6) else flag_mismatch("wrong packet count after release");
        for (int i = 1; i < pkt_order.size(); i++) begin
            assert (pkt_order[i] != pkt_order[i-1])
                else flag_mismatch($sformatf("packet %0d did not alternate context", i));
        end
        finish_test(4, "round robin", err_start);

        err_start = err_cnt;
        set_rdy(RDY_RANDOM);
        for (int p = 0; p < 10; p++) begin
            send_packet(ctxt_t'(next_stim() >> 31), pick_len(MAX_PKT_WORDS));
        end
        wait_drain();
        set_rdy(RDY_HIGH);
        finish_test(5, "random back-pressure", err_start);

        // 36 words into one 32-word region with the output held
        err_start = err_cnt;
        set_rdy(RDY_LOW);
        fork
            begin
                for (int p = 0; p < 3; p++) begin
                    send_packet(1'b0, 12);
                end
            end
            begin
                stall_cycles = 0;
                waited       = 0;
                while (stall_cycles < 8 && waited < 400) begin
                    @(posedge clk);
                    waited++;
                    if (in_valid && !in_rdy) begin
                        stall_cycles++;
                    end
                end
                if (stall_cycles < 8) begin
                    flag_failure("in_rdy never fell while the region was full");
                end
                set_rdy(RDY_HIGH);
            end
        join
        wait_drain();
        finish_test(6, "region full", err_start);

        $display("tests 6, tests with errors %0d, errors %0d, words checked %0d",
                 bad_tests, err_cnt, words_out);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : packet_buffer_tb

`default_nettype wire

// File: verilog.f
source/packet_pkg.sv
source/packet_mem.sv
source/mem_arbiter.sv
source/packet_enqueue.sv
source/packet_dequeue.sv
source/packet_buffer_top.sv
verification/packet_buffer_tb.sv

// File: Bender.yml
package:
  name: packet_buffer

sources:
  - files:
      - source/packet_pkg.sv
      - source/packet_mem.sv
      - source/mem_arbiter.sv
      - source/packet_enqueue.sv
      - source/packet_dequeue.sv
      - source/packet_buffer_top.sv

  - target: test
    files:
      - verification/packet_buffer_tb.sv
